// File: hdl/iq_pkg.sv
// Instruction queue shared definitions
`default_nettype none

package iq_pkg;

	// ==================================================
	// queue geometry
	// ==================================================

	// number of entries in the circular instruction queue
	localparam int QENTRIES = 8;

	// fetch slots presented to dispatch every cycle
	localparam int QSLOTS = 3;

	// width of one sequence number
	// the live numbers never exceed the occupancy, so eight bits is generous
	localparam int SNBITS = 8;

	// index of one queue entry
	typedef logic [2:0] qidx_t;

	// sequence number carried by each entry
	typedef logic [SNBITS-1:0] sn_t;

	// small count, 0 to 3 for slots and commits, 0 to 7 for low occupancy bits
	typedef logic [2:0] cnt_t;

	// occupancy of the queue, 0 to QENTRIES inclusive
	typedef logic [3:0] occ_t;

	// one bit per fetch slot
	typedef logic [QSLOTS-1:0] slot_vec_t;

	// ==================================================
	// APB register map
	// ==================================================

	// control, bit 0 holds debug_on
	localparam logic [7:0] REG_CTRL = 8'h00;
	// read-only status words
	localparam logic [7:0] REG_MAXSN = 8'h04;
	localparam logic [7:0] REG_OCC = 8'h08;
	localparam logic [7:0] REG_HEAD = 8'h0C;
	// entry n is read at REG_SN_BASE plus four times n
	localparam logic [7:0] REG_SN_BASE = 8'h20;

endpackage

`default_nettype wire

// File: hdl/iq_state_if.sv
// Queue state bundle
`default_nettype none

// carries the queue contents to the sequence-number tracker and brings
// back the two search results the queue needs at the next edge
interface iq_state_if;

	// ==================================================
	// driven by the queue
	// ==================================================

	// one valid bit per entry
	logic [iq_pkg::QENTRIES-1:0] iq_v;

	// sequence number held by each entry
	iq_pkg::sn_t iq_sn [iq_pkg::QENTRIES];

	// heads[i] is the entry that sits i places from the head
	iq_pkg::qidx_t heads [iq_pkg::QENTRIES];

	// number of head entries retiring this cycle, already capped by occupancy
	iq_pkg::cnt_t hi_amt;

	// ==================================================
	// driven by the tracker
	// ==================================================

	// largest sequence number among the valid entries
	iq_pkg::sn_t maxsn;

	// amount taken off every surviving entry at commit
	iq_pkg::sn_t tosub;

	// the queue owns the arrays and uses the search results
	modport queue (output iq_v, iq_sn, heads, hi_amt, input maxsn, tosub);

	// the tracker only looks at the arrays
	modport tracker (input iq_v, iq_sn, heads, hi_amt, output maxsn, tosub);

endinterface

`default_nettype wire

// File: hdl/seqnum.sv
// Sequence number search
`default_nettype none

// purely combinational, both results are used by the queue at the next edge
module seqnum
(
	iq_state_if.tracker st
);

	// search results before they are handed to the interface
	iq_pkg::sn_t maxsn_c;
	iq_pkg::sn_t tosub_c;

	// ==================================================
	// largest live sequence number
	// ==================================================

	// a plain scan over every entry
	// invalid entries may hold stale numbers so they are skipped
	always_comb
	begin
		maxsn_c = '0;
		for (int n = 0; n < iq_pkg::QENTRIES; n++)
		begin
			if (st.iq_v[n] && st.iq_sn[n] > maxsn_c)
			begin
				maxsn_c = st.iq_sn[n];
			end
		end
	end

	// ==================================================
	// commit subtrahend
	// ==================================================

	// walk the heads in age order and keep the number of the youngest
	// valid entry that retires this cycle
	// with no commit the result stays zero and nothing is renumbered
	always_comb
	begin
		tosub_c = '0;
		for (int j = 0; j < iq_pkg::QENTRIES; j++)
		begin
			if (j < int'(st.hi_amt))
			begin
				// only a valid head contributes its number
				if (st.iq_v[st.heads[j]])
				begin
					tosub_c = st.iq_sn[st.heads[j]];
				end
			end
		end
	end

	// numbers run 1 to occupancy from the head, so maxsn equals the occupancy
	// and tosub equals the number of entries retiring
	assign st.maxsn = maxsn_c;
	assign st.tosub = tosub_c;

endmodule

`default_nettype wire

// File: hdl/dispatch_sel.sv
// Dispatch slot selector
`default_nettype none

// decides how many of the fetched slots enter the queue this cycle
// the enqueued slots are always the first ones of the group
module dispatch_sel
(
	input  logic              phit,
	input  iq_pkg::slot_vec_t slotv,
	input  iq_pkg::slot_vec_t take_branch,
	input  logic              branchmiss,
	input  logic              debug_on,
	input  iq_pkg::occ_t      occ,
	output iq_pkg::cnt_t      dispatch_count
);

	// slots that are really present this cycle
	iq_pkg::slot_vec_t live_c;
	// in-order count before any capping
	iq_pkg::cnt_t      raw_cnt;
	// set once a taken branch has been counted
	logic              stop_c;
	// free entries, counted before this cycle's commit
	iq_pkg::occ_t      free_c;
	// count after the capacity and mode limits
	iq_pkg::cnt_t      cnt_c;

	// a missed fetch presents nothing
	assign live_c = slotv & {iq_pkg::QSLOTS{phit}};

	// free space in the queue
	assign free_c = iq_pkg::occ_t'(iq_pkg::QENTRIES) - occ;

	// ==================================================
	// in-order count up to the first taken branch
	// ==================================================

	// slots are examined from 0 upwards
	// the taken branch itself is counted and anything after it is dropped
	always_comb
	begin
		raw_cnt = '0;
		stop_c = 1'b0;
		for (int i = 0; i < iq_pkg::QSLOTS; i++)
		begin
			if (live_c[i] && !stop_c)
			begin
				raw_cnt = raw_cnt + iq_pkg::cnt_t'(1);
				if (take_branch[i])
				begin
					stop_c = 1'b1;
				end
			end
		end
	end

	// ==================================================
	// limits
	// ==================================================

	always_comb
	begin
		cnt_c = raw_cnt;
		// a full queue brings the count to zero and fetch holds the slots
		if (iq_pkg::occ_t'(raw_cnt) > free_c)
		begin
			cnt_c = free_c[2:0];
		end
		// single stepping lets one instruction in at a time
		if (debug_on && cnt_c > iq_pkg::cnt_t'(1))
		begin
			cnt_c = iq_pkg::cnt_t'(1);
		end
		// nothing enters while the front end is redirecting
		if (branchmiss)
		begin
			cnt_c = '0;
		end
	end

	assign dispatch_count = cnt_c;

endmodule

`default_nettype wire

// File: hdl/iq_seq_queue.sv
// Instruction queue with renumbering
`default_nettype none

// eight-entry circular queue holding only a valid bit and a sequence number
// per entry, enqueue and commit happen together in one edge
module iq_seq_queue
(
	input  logic          clk,
	input  logic          arst_n,
	input  iq_pkg::cnt_t  dispatch_count,
	input  iq_pkg::cnt_t  commit_amt,
	output iq_pkg::occ_t  occ,
	output iq_pkg::qidx_t head,
	iq_state_if.queue     st
);

	// ==================================================
	// state
	// ==================================================

	logic [iq_pkg::QENTRIES-1:0] v_q;
	iq_pkg::sn_t                 sn_q [iq_pkg::QENTRIES];
	iq_pkg::qidx_t               head_q;
	iq_pkg::qidx_t               tail_q;
	iq_pkg::occ_t                occ_q;

	// next-state values and helpers
	logic [iq_pkg::QENTRIES-1:0] v_nxt;
	iq_pkg::sn_t                 sn_nxt [iq_pkg::QENTRIES];
	iq_pkg::qidx_t               heads_c [iq_pkg::QENTRIES];
	iq_pkg::qidx_t               wr_idx [iq_pkg::QSLOTS];
	iq_pkg::cnt_t                commit_c;

	// commit can never retire more entries than the queue holds
	assign commit_c = (occ_q < iq_pkg::occ_t'(commit_amt)) ? occ_q[2:0] : commit_amt;

	// age order view of the queue, heads_c[0] is the oldest entry
	always_comb
	begin
		for (int i = 0; i < iq_pkg::QENTRIES; i++)
		begin
			heads_c[i] = head_q + iq_pkg::qidx_t'(i);
		end
	end

	// entries written by this cycle's dispatch, wrapping past the last entry
	always_comb
	begin
		for (int k = 0; k < iq_pkg::QSLOTS; k++)
		begin
			wr_idx[k] = tail_q + iq_pkg::qidx_t'(k);
		end
	end

	// ==================================================
	// next valid bits
	// ==================================================

	// dispatch is capped by the free space before commit, so the tail
	// entries written here are never among the retiring head entries
	always_comb
	begin
		v_nxt = v_q;
		for (int i = 0; i < iq_pkg::QSLOTS; i++)
		begin
			if (i < int'(commit_c))
			begin
				v_nxt[heads_c[i]] = 1'b0;
			end
		end
		for (int k = 0; k < iq_pkg::QSLOTS; k++)
		begin
			if (k < int'(dispatch_count))
			begin
				v_nxt[wr_idx[k]] = 1'b1;
			end
		end
	end

	// ==================================================
	// next sequence numbers
	// ==================================================

	// survivors slide down by tosub so the oldest live entry becomes 1
	// new entries continue from the renumbered maximum
	always_comb
	begin
		for (int n = 0; n < iq_pkg::QENTRIES; n++)
		begin
			sn_nxt[n] = sn_q[n];
			if (v_q[n])
			begin
				sn_nxt[n] = sn_q[n] - st.tosub;
			end
		end
		for (int k = 0; k < iq_pkg::QSLOTS; k++)
		begin
			if (k < int'(dispatch_count))
			begin
				sn_nxt[wr_idx[k]] = st.maxsn - st.tosub + iq_pkg::sn_t'(k + 1);
			end
		end
	end

	// control state
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			v_q <= '0;
			head_q <= '0;
			tail_q <= '0;
			occ_q <= '0;
		end
		else
		begin
			v_q <= v_nxt;
			head_q <= head_q + commit_c;
			tail_q <= tail_q + dispatch_count;
			occ_q <= occ_q - iq_pkg::occ_t'(commit_c) + iq_pkg::occ_t'(dispatch_count);
		end
	end

	// per-entry sequence numbers, renumbered at every edge
	always_ff @(posedge clk)
	begin
		sn_q <= sn_nxt;
	end

	// state seen by the tracker and the status block
	assign st.iq_v = v_q;
	assign st.iq_sn = sn_q;
	assign st.heads = heads_c;
	assign st.hi_amt = commit_c;
	assign occ = occ_q;
	assign head = head_q;

endmodule

`default_nettype wire

// File: hdl/iq_status_apb.sv
// APB control and status slave
`default_nettype none

// zero wait-state APB slave, the transfer is taken in the access phase
module iq_status_apb
(
	input  logic          clk,
	input  logic          arst_n,
	input  logic          psel,
	input  logic          penable,
	input  logic          pwrite,
	input  logic [7:0]    paddr,
	input  logic [31:0]   pwdata,
	output logic [31:0]   prdata,
	output logic          pready,
	output logic          pslverr,
	output logic          debug_on,
	input  iq_pkg::sn_t   maxsn,
	input  iq_pkg::occ_t  occ,
	input  iq_pkg::qidx_t head,
	input  iq_pkg::sn_t   iq_sn [iq_pkg::QENTRIES]
);

	// access phase of a transfer
	logic          access;
	// decode results
	logic          mapped_c;
	logic          ro_c;
	logic [31:0]   rdata_c;
	// entry selected by the windowed read
	iq_pkg::qidx_t sn_sel;
	// the only writable bit in the map
	logic          debug_q;

	assign access = psel & penable;
	assign sn_sel = paddr[4:2];

	// ==================================================
	// address decode and read mux
	// ==================================================

	always_comb
	begin
		rdata_c = '0;
		mapped_c = 1'b1;
		ro_c = 1'b1;
		case (paddr)
			iq_pkg::REG_CTRL:
			begin
				rdata_c = {31'b0, debug_q};
				ro_c = 1'b0;
			end
			iq_pkg::REG_MAXSN: rdata_c = 32'(maxsn);
			iq_pkg::REG_OCC:   rdata_c = 32'(occ);
			iq_pkg::REG_HEAD:  rdata_c = 32'(head);
			default:
			begin
				// word aligned addresses inside the entry window
				// the raw number comes back even for an empty entry
				if (paddr[7:5] == iq_pkg::REG_SN_BASE[7:5] && paddr[1:0] == 2'b00)
				begin
					rdata_c = 32'(iq_sn[sn_sel]);
				end
				else
				begin
					mapped_c = 1'b0;
				end
			end
		endcase
	end

	// ==================================================
	// control register
	// ==================================================

	// only a clean write to REG_CTRL lands, errored writes change nothing
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			debug_q <= 1'b0;
		else if (access && pwrite && paddr == iq_pkg::REG_CTRL)
			debug_q <= pwdata[0];
	end

	// read data is valid in the same access cycle
	assign prdata = (access && !pwrite) ? rdata_c : '0;
	assign pready = 1'b1;
	// unmapped address or a write aimed at a status word
	assign pslverr = access & (~mapped_c | (pwrite & ro_c));
	assign debug_on = debug_q;

endmodule

`default_nettype wire

// File: hdl/iq_seq_top.sv
// Sequence number tracker top
`default_nettype none

// dispatch and commit arrive on plain ports, the host sees the block
// through the APB slave
module iq_seq_top
(
	input  logic              clk,
	input  logic              arst_n,
	// fetch group presented to dispatch
	input  logic              phit,
	input  iq_pkg::slot_vec_t slotv,
	input  iq_pkg::slot_vec_t take_branch,
	input  logic              branchmiss,
	// retire request from the back end
	input  iq_pkg::cnt_t      commit_amt,
	// how many slots entered the queue this cycle
	output iq_pkg::cnt_t      dispatch_count,
	// APB slave
	input  logic              psel,
	input  logic              penable,
	input  logic              pwrite,
	input  logic [7:0]        paddr,
	input  logic [31:0]       pwdata,
	output logic [31:0]       prdata,
	output logic              pready,
	output logic              pslverr
);

	// single step mode from the control register
	logic          debug_on;
	// queue fill level and oldest entry
	iq_pkg::occ_t  occ;
	iq_pkg::qidx_t head;

	// queue contents shared with the tracker
	iq_state_if st_if ();

	// maxsn and tosub search
	seqnum u_seqnum
	(
		.st (st_if.tracker)
	);

	// dispatch width is decided before the queue is updated
	dispatch_sel u_dispatch_sel
	(
		.phit           (phit),
		.slotv          (slotv),
		.take_branch    (take_branch),
		.branchmiss     (branchmiss),
		.debug_on       (debug_on),
		.occ            (occ),
		.dispatch_count (dispatch_count)
	);

	// the queue applies enqueue, commit and renumbering in one edge
	iq_seq_queue u_queue
	(
		.clk            (clk),
		.arst_n         (arst_n),
		.dispatch_count (dispatch_count),
		.commit_amt     (commit_amt),
		.occ            (occ),
		.head           (head),
		.st             (st_if.queue)
	);

	// host control and status
	iq_status_apb u_status_apb
	(
		.clk      (clk),
		.arst_n   (arst_n),
		.psel     (psel),
		.penable  (penable),
		.pwrite   (pwrite),
		.paddr    (paddr),
		.pwdata   (pwdata),
		.prdata   (prdata),
		.pready   (pready),
		.pslverr  (pslverr),
		.debug_on (debug_on),
		.maxsn    (st_if.maxsn),
		.occ      (occ),
		.head     (head),
		.iq_sn    (st_if.iq_sn)
	);

endmodule

`default_nettype wire

// File: tests/iq_seq_tb.sv
// Sequence tracker testbench
`default_nettype none

module iq_seq_tb;

	timeunit 1ns;
	timeprecision 100ps;

	// ==================================================
	// run length and clocking
	// ==================================================

	localparam int CLK_NS = 100;
	localparam int RAND_CYCLES = 400;
	// a random cycle plus up to eleven two-cycle status reads stays under 24,
	// the directed sections fit easily in the fixed part
	localparam int MAX_CYCLES = 1000 + RAND_CYCLES * 24;

	logic              clk;
	logic              arst_n;
	logic              phit;
	iq_pkg::slot_vec_t slotv;
	iq_pkg::slot_vec_t take_branch;
	logic              branchmiss;
	iq_pkg::cnt_t      commit_amt;
	iq_pkg::cnt_t      dispatch_count;
	logic              psel;
	logic              penable;
	logic              pwrite;
	logic [7:0]        paddr;
	logic [31:0]       pwdata;
	logic [31:0]       prdata;
	logic              pready;
	logic              pslverr;

	// reference model state
	int          occ_m;
	int          head_m;
	logic        dbg_m;
	logic [31:0] seed;

	iq_seq_top dut0
	(
		.clk            (clk),
		.arst_n         (arst_n),
		.phit           (phit),
		.slotv          (slotv),
		.take_branch    (take_branch),
		.branchmiss     (branchmiss),
		.commit_amt     (commit_amt),
		.dispatch_count (dispatch_count),
		.psel           (psel),
		.penable        (penable),
		.pwrite         (pwrite),
		.paddr          (paddr),
		.pwdata         (pwdata),
		.prdata         (prdata),
		.pready         (pready),
		.pslverr        (pslverr)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_NS / 2) clk = ~clk;
	end

	// ==================================================
	// reference model
	// ==================================================

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	// in-order count up to and including the first taken branch,
	// then the free space, debug and branch miss limits
	function automatic iq_pkg::cnt_t expected_dispatch(input logic hit,
		input iq_pkg::slot_vec_t sv, input iq_pkg::slot_vec_t br,
		input logic miss, input logic dbg, input int occ_now);
		int n;
		int free;
		n = 0;
		for (int i = 0; i < iq_pkg::QSLOTS; i++)
		begin
			if (hit && sv[i])
			begin
				n++;
				if (br[i])
					break;
			end
		end
		free = iq_pkg::QENTRIES - occ_now;
		if (n > free)
			n = free;
		if (dbg && n > 1)
			n = 1;
		if (miss)
			n = 0;
		return iq_pkg::cnt_t'(n);
	endfunction

	// one clock edge of the model, free space is taken before the commit
	task automatic ref_step();
		int dc;
		int cm;
		dc = int'(expected_dispatch(phit, slotv, take_branch, branchmiss, dbg_m, occ_m));
		cm = int'(commit_amt);
		if (cm > occ_m)
			cm = occ_m;
		occ_m = occ_m - cm + dc;
		head_m = (head_m + cm) % iq_pkg::QENTRIES;
		if (psel && penable && pwrite && paddr == iq_pkg::REG_CTRL)
			dbg_m = pwdata[0];
	endtask

	always @(posedge clk)
	begin
		if (arst_n)
			ref_step();
	end

	// ==================================================
	// compare tasks
	// ==================================================

	task automatic check_cnt(input string name, input iq_pkg::cnt_t got, input iq_pkg::cnt_t exp);
		if (got !== exp)
		begin
			$display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
			$display("Some tests failed");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	task automatic check_sn(input string name, input iq_pkg::sn_t got, input iq_pkg::sn_t exp);
		if (got !== exp)
		begin
			$display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
			$display("Some tests failed");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
			$display("Some tests failed");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
			$display("Some tests failed");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	// dispatch_count is combinational, so it is settled by the falling edge
	always @(negedge clk)
	begin
		if (arst_n)
			check_cnt("dispatch_count", dispatch_count,
				expected_dispatch(phit, slotv, take_branch, branchmiss, dbg_m, occ_m));
	end

	// ==================================================
	// stimulus tasks
	// ==================================================

	// every task starts and ends 10 ns after a rising edge with idle inputs
	task automatic drive_cycle(input logic hit, input iq_pkg::slot_vec_t sv,
		input iq_pkg::slot_vec_t br, input logic miss, input iq_pkg::cnt_t cm);
		phit = hit;
		slotv = sv;
		take_branch = br;
		branchmiss = miss;
		commit_amt = cm;
		@(posedge clk);
		#10;
		phit = 1'b0;
		slotv = '0;
		take_branch = '0;
		branchmiss = 1'b0;
		commit_amt = '0;
	endtask

	// setup phase, then the access phase where data and error are sampled
	task automatic apb_transfer(input logic wr, input logic [7:0] addr,
		input logic [31:0] wdata, output logic [31:0] rdata, output logic err);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = wr;
		paddr = addr;
		pwdata = wdata;
		@(posedge clk);
		#10;
		penable = 1'b1;
		#40;
		rdata = prdata;
		err = pslverr;
		check_flag("pready", pready, 1'b1);
		@(posedge clk);
		#10;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
	endtask

	task automatic read_word(input logic [7:0] addr, input string name, input logic [31:0] exp);
		logic [31:0] rd;
		logic        err;
		apb_transfer(1'b0, addr, 32'h0, rd, err);
		check_flag("pslverr", err, 1'b0);
		check_word(name, rd, exp);
	endtask

	// status words carrying a sequence number are zero-extended
	task automatic read_sn(input logic [7:0] addr, input string name, input iq_pkg::sn_t exp);
		logic [31:0] rd;
		logic        err;
		apb_transfer(1'b0, addr, 32'h0, rd, err);
		check_flag("pslverr", err, 1'b0);
		check_word("prdata upper bits", rd >> iq_pkg::SNBITS, 32'h0);
		check_sn(name, iq_pkg::sn_t'(rd), exp);
	endtask

	// live numbers run 1 to occupancy counted from the head
	task automatic verify_queue();
		int idx;
		read_sn(iq_pkg::REG_MAXSN, "maxsn", iq_pkg::sn_t'(occ_m));
		read_word(iq_pkg::REG_OCC, "occ", 32'(occ_m));
		read_word(iq_pkg::REG_HEAD, "head", 32'(head_m));
		for (int i = 0; i < occ_m; i++)
		begin
			idx = (head_m + i) % iq_pkg::QENTRIES;
			read_sn(iq_pkg::REG_SN_BASE + 8'(4 * idx), $sformatf("sn[%0d]", idx),
				iq_pkg::sn_t'(i + 1));
		end
	endtask

	task automatic drain_queue();
		repeat (3) drive_cycle(1'b0, '0, '0, 1'b0, iq_pkg::cnt_t'(3));
	endtask

	// ==================================================
	// test sequence
	// ==================================================

	initial
	begin
		logic [31:0] rd;
		logic        err;
		logic [7:0]  pat;
		arst_n = 1'b0;
		phit = 1'b0;
		slotv = '0;
		take_branch = '0;
		branchmiss = 1'b0;
		commit_amt = '0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		occ_m = 0;
		head_m = 0;
		dbg_m = 1'b0;
		seed = 32'h06ad_1825;
		repeat (5) @(posedge clk);
		#10;
		arst_n = 1'b1;

		// state right after reset
		read_sn(iq_pkg::REG_MAXSN, "maxsn", '0);
		read_word(iq_pkg::REG_OCC, "occ", 32'h0);
		read_word(iq_pkg::REG_CTRL, "ctrl", 32'h0);

		// every selector input pattern on an empty queue, drained after each
		for (int p = 0; p < 256; p++)
		begin
			pat = 8'(p);
			drive_cycle(pat[6], pat[2:0], pat[5:3], pat[7], '0);
			drive_cycle(1'b0, '0, '0, 1'b0, iq_pkg::cnt_t'(3));
		end

		// fill up to eight, the last cycles are capped and then stalled
		repeat (5) drive_cycle(1'b1, 3'b111, '0, 1'b0, '0);
		verify_queue();
		drain_queue();

		// single stepping
		apb_transfer(1'b1, iq_pkg::REG_CTRL, 32'h1, rd, err);
		check_flag("pslverr", err, 1'b0);
		read_word(iq_pkg::REG_CTRL, "ctrl", 32'h1);
		repeat (3) drive_cycle(1'b1, 3'b111, '0, 1'b0, '0);
		verify_queue();
		drain_queue();
		apb_transfer(1'b1, iq_pkg::REG_CTRL, 32'h0, rd, err);
		check_flag("pslverr", err, 1'b0);

		// random dispatch and commit, mostly hitting, with rare misses
		repeat (RAND_CYCLES)
		begin
			seed = xorshift32(seed);
			drive_cycle(seed[0] | seed[1], seed[4:2], seed[7:5] & {3{seed[8]}},
				seed[11:9] == 3'b000, iq_pkg::cnt_t'(seed[13:12]));
			verify_queue();
		end
		drain_queue();

		// one entry, then a commit of three
		drive_cycle(1'b1, 3'b001, '0, 1'b0, '0);
		drive_cycle(1'b0, '0, '0, 1'b0, iq_pkg::cnt_t'(3));
		read_word(iq_pkg::REG_OCC, "occ", 32'h0);
		read_sn(iq_pkg::REG_MAXSN, "maxsn", '0);

		// error responses, keep one entry so a write to maxsn would show
		drive_cycle(1'b1, 3'b001, '0, 1'b0, '0);
		apb_transfer(1'b1, iq_pkg::REG_MAXSN, 32'hff, rd, err);
		check_flag("pslverr", err, 1'b1);
		apb_transfer(1'b0, 8'h10, 32'h0, rd, err);
		check_flag("pslverr", err, 1'b1);
		apb_transfer(1'b1, iq_pkg::REG_SN_BASE, 32'h5, rd, err);
		check_flag("pslverr", err, 1'b1);
		verify_queue();
		read_word(iq_pkg::REG_CTRL, "ctrl", 32'h0);

		$display("All tests passed");
		$finish;
	end

	// ends a run that stops making progress
	initial
	begin
		#(MAX_CYCLES * CLK_NS);
		$display("Some tests failed");
		$fatal(1, "watchdog expired after %0d cycles before the tests completed", MAX_CYCLES);
	end

endmodule

`default_nettype wire

// File: iq_seq_top.f
hdl/iq_pkg.sv
hdl/iq_state_if.sv
hdl/seqnum.sv
hdl/dispatch_sel.sv
hdl/iq_seq_queue.sv
hdl/iq_status_apb.sv
hdl/iq_seq_top.sv
tests/iq_seq_tb.sv

// File: Makefile
# Verilator build and run of the sequence number tracker testbench

SIM = iq_seq_sim

all: run

run: build
	./obj_dir/$(SIM)

build:
	verilator --binary --timing --timescale 1ns/100ps \
		-f iq_seq_top.f --top-module iq_seq_tb -o $(SIM)

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/100ps \
		-f iq_seq_top.f --top-module iq_seq_top

clean:
	rm -rf obj_dir

.PHONY: all run build lint clean
